// File: compile.f
+incdir+test
src/game_pkg.sv
src/map_control.sv
src/move_ctrl.sv
src/pos_update.sv
src/wb_regs.sv
src/char_top.sv
test/char_tb.sv

// File: test/char_model.svh
//####################################################################
// behavioral model of the character built from the package tables.
// loaded positions must lie on screen, the model does not wrap them.
//####################################################################

`ifndef CHAR_MODEL_SVH
`define CHAR_MODEL_SVH

int model_x;
int model_y;

function automatic bit ladder_at(input int x, input int y, output int lo, output int hi);
    lo = 0;
    hi = 0;
    for (int k = 0; k < LADDER_COUNT; k++) begin
        if (y >= LADDER_VSTART[k] - CHAR_HEIGHT && y <= LADDER_VSTOP[k] &&
            x >= LADDER_HSTART[k] - LADDER_OFFSET &&
            x <= LADDER_HSTART[k] - LADDER_OFFSET + LADDER_WIDTH) begin
            lo = LADDER_VSTART[k] - CHAR_HEIGHT;
            hi = LADDER_VSTOP[k] - CHAR_HEIGHT;
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic slope_e slope_at(input int x, input int y);
    for (int k = 0; k < RAMP_COUNT; k++) begin
        if (x >= RAMP_XMIN[k] && x <= RAMP_XMAX[k] &&
            y >= RAMP_YMIN[k] && y <= RAMP_YMAX[k])
            return RAMP_DIR[k];
    end
    return SLOPE_FLAT;
endfunction

function automatic bit edge_at(input int x, input int y, output int land);
    land = 0;
    for (int k = 0; k < EDGE_COUNT; k++) begin
        if (x >= EDGE_XMIN[k] && x <= EDGE_XMAX[k] && y >= EDGE_YMIN[k] && y <= EDGE_YMAX[k]) begin
            land = EDGE_LAND[k];
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

function automatic logic [15:0] status_of(input int x, input int y);
    int          lo;
    int          hi;
    int          land;
    logic [15:0] s;
    s      = 16'h0000;          // busy is low once a command has finished.
    s[1]   = ladder_at(x, y, lo, hi);
    s[3:2] = slope_at(x, y);
    s[4]   = edge_at(x, y, land);
    return s;
endfunction

function automatic void run_cmd(input cmd_e op, input int steps);
    int     lo;
    int     hi;
    int     land;
    int     dx;
    slope_e sl;
    for (int n = 0; n < steps; n++) begin
        if (op == CMD_LEFT || op == CMD_RIGHT) begin
            sl = slope_at(model_x, model_y);
            dx = (op == CMD_RIGHT) ? 1 : -1;
            if (model_x + dx >= 0 && model_x + dx <= HOR_PIXELS - CHAR_WIDTH) begin
                model_x += dx;
                if (sl != SLOPE_FLAT && model_x % RAMP_RUN == 0)
                    model_y += (sl == SLOPE_DOWN_RIGHT) ? dx : -dx;
            end
            if (edge_at(model_x, model_y, land)) begin
                model_y = land;     // the rest of the walk is lost in the fall.
                return;
            end
        end else if ((op == CMD_UP || op == CMD_DOWN) && ladder_at(model_x, model_y, lo, hi)) begin
            if (op == CMD_UP && model_y > lo)
                model_y--;
            if (op == CMD_DOWN && model_y < hi)
                model_y++;
        end
    end
endfunction

`endif

// File: test/char_tb.sv
//####################################################################
// inputs change on the falling clock edge and every wait has a timeout.
// stimulus keeps loaded positions on screen and away from wrap-around.
//####################################################################

module char_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import game_pkg::*;

    localparam int ACK_TIMEOUT  = 16;
    localparam int BUSY_TIMEOUT = 1500;    // polls, each one a full bus read.

    logic           clk;
    logic           rst;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    logic [1:0]     wb_adr;
    logic [15:0]    wb_dat_w;
    logic           wb_ack;
    logic [15:0]    wb_dat_r;
    int             checks;
    int             errors;
    int             test_errors;

    `include "char_model.svh"

    char_top UUT (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_ack, .wb_dat_r
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic void count_error();
        errors++;
        test_errors++;
    endfunction

    task automatic bus_access(input logic we, input logic [1:0] adr, input logic [15:0] wdata,
                              output logic [15:0] rdata);
        int waited;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_TIMEOUT);
        rdata = wb_dat_r;
        assert (wb_ack) else begin
            $display("no ack from bus at register %0d", adr);
            count_error();
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;      // one idle clock follows before the next strobe.
        wb_we  = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            count_error();
        end
    endtask

    task automatic check_state();
        logic [15:0] got;
        bus_access(1'b0, REG_X, 16'h0000, got);
        check_value("x", got, 16'(model_x));
        bus_access(1'b0, REG_Y, 16'h0000, got);
        check_value("y", got, 16'(model_y));
        bus_access(1'b0, REG_STATUS, 16'h0000, got);
        check_value("status", got, status_of(model_x, model_y));
    endtask

    task automatic place(input int x, input int y);
        logic [15:0] rd;
        bus_access(1'b1, REG_X, 16'(x), rd);
        bus_access(1'b1, REG_Y, 16'(y), rd);
        model_x = x;
        model_y = y;
        check_state();
    endtask

    task automatic finish_cmd();
        logic [15:0] st;
        int          polls;
        polls = 0;
        do begin
            bus_access(1'b0, REG_STATUS, 16'h0000, st);
            polls++;
        end while (st[0] && polls < BUSY_TIMEOUT);
        assert (!st[0]) else begin
            $display("command never finished");
            count_error();
        end
        check_state();
    endtask

    task automatic command(input cmd_e op, input int steps);
        logic [15:0] rd;
        bus_access(1'b1, REG_CMD, {8'(steps), 5'd0, op}, rd);
        run_cmd(op, steps);
        finish_cmd();
    endtask

    task automatic end_test(input string name);
        $display("test %s done with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        logic [15:0] rd;
        void'($urandom(97608));
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        rst         = 1'b1;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = 2'd0;
        wb_dat_w    = 16'h0000;
        model_x     = 0;
        model_y     = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        check_state();
        end_test("reset");

        for (int i = 0; i < 8; i++) begin
            place($urandom_range(HOR_PIXELS - CHAR_WIDTH, 0), 100);
            command(($urandom_range(1, 0) == 1) ? CMD_RIGHT : CMD_LEFT, $urandom_range(255, 1));
        end
        place(500, 100);        // room to move either way, so a stray step shows.
        command(CMD_NOP, 9);
        command(CMD_RIGHT, 0);
        end_test("flat walks");

        for (int k = 0; k < RAMP_COUNT; k++) begin
            for (int j = 0; j < 2; j++) begin
                place($urandom_range(RAMP_XMAX[k] - 40, RAMP_XMIN[k] + 40),
                      $urandom_range(RAMP_YMAX[k] - 12, RAMP_YMIN[k] + 12));
                command((j == 0) ? CMD_RIGHT : CMD_LEFT, $urandom_range(80, 8));
            end
        end
        end_test("ramps");

        // the step counts cover the whole ladder height, so both limits are hit.
        for (int k = 0; k < LADDER_COUNT; k++) begin
            place(LADDER_HSTART[k] - LADDER_OFFSET + $urandom_range(LADDER_WIDTH, 0),
                  $urandom_range(LADDER_VSTOP[k] - CHAR_HEIGHT, LADDER_VSTART[k] - CHAR_HEIGHT));
            command(CMD_UP, $urandom_range(255, 200));
            command(CMD_DOWN, $urandom_range(255, 200));
        end
        place(500, 100);
        command(CMD_UP, 20);
        command(CMD_DOWN, 20);
        end_test("ladders");

        for (int k = 0; k < EDGE_COUNT; k++) begin
            if (EDGE_XMIN[k] > 20) begin
                place(EDGE_XMIN[k] - $urandom_range(20, 1),
                      $urandom_range(EDGE_YMAX[k], EDGE_YMIN[k]));
                command(CMD_RIGHT, $urandom_range(100, 30));
            end else begin
                place(EDGE_XMAX[k] + $urandom_range(20, 1),
                      $urandom_range(EDGE_YMAX[k], EDGE_YMIN[k]));
                command(CMD_LEFT, $urandom_range(100, 30));
            end
            bus_access(1'b0, REG_Y, 16'h0000, rd);
            check_value("y", rd, 16'(EDGE_LAND[k]));
            place(EDGE_XMIN[k], EDGE_YMAX[k]);     // a load alone leaves the edge flag set.
        end
        end_test("platform ends");

        place(500, 100);
        bus_access(1'b1, REG_CMD, {8'd40, 5'd0, CMD_RIGHT}, rd);
        run_cmd(CMD_RIGHT, 40);
        bus_access(1'b1, REG_X, 16'd10, rd);
        bus_access(1'b1, REG_Y, 16'd10, rd);
        bus_access(1'b1, REG_CMD, {8'd5, 5'd0, CMD_LEFT}, rd);
        finish_cmd();
        end_test("busy writes");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src/char_top.sv
//####################################################################
// host waits on the status busy bit, there is no internal back-pressure.
//####################################################################

module char_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [1:0]  wb_adr,
    input  logic [15:0] wb_dat_w,
    output logic        wb_ack,
    output logic [15:0] wb_dat_r
);

    import game_pkg::*;

    logic               busy;
    logic               cmd_start;
    cmd_e               cmd_op;
    logic [7:0]         cmd_steps;
    logic               load_x;
    logic               load_y;
    logic [POS_W-1:0]   load_val;
    logic               step_en;
    cmd_e               step_op;
    logic               fall_en;
    logic [POS_W-1:0]   xpos;
    logic [POS_W-1:0]   ypos;
    logic               landed;
    logic               ladder;
    logic [POS_W-1:0]   limit_ymin;
    logic [POS_W-1:0]   limit_ymax;
    slope_e             slope;
    logic               on_edge;
    logic [POS_W-1:0]   land_y;

    wb_regs u_wb_regs (
        .clk, .rst, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .busy, .xpos, .ypos, .ladder, .slope, .on_edge,
        .wb_ack, .wb_dat_r, .cmd_start, .cmd_op, .cmd_steps,
        .load_x, .load_y, .load_val
    );

    move_ctrl u_move_ctrl (
        .clk, .rst, .cmd_start, .cmd_op, .cmd_steps, .ladder, .on_edge, .landed,
        .busy, .step_en, .step_op, .fall_en
    );

    pos_update u_pos_update (
        .clk, .rst, .load_x, .load_y, .load_val, .step_en, .step_op, .fall_en,
        .slope, .limit_ymin, .limit_ymax, .land_y, .xpos, .ypos, .landed
    );

    map_control u_map_control (
        .clk, .rst, .xpos, .ypos, .ladder, .limit_ymin, .limit_ymax,
        .slope, .on_edge, .land_y
    );

endmodule

// File: src/wb_regs.sv
//####################################################################
// one ack per strobe, the master must drop stb before the next cycle.
// writes to command and position registers are dropped while busy.
//####################################################################

module wb_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [1:0]                  wb_adr,
    input  logic [15:0]                 wb_dat_w,
    input  logic                        busy,
    input  logic [game_pkg::POS_W-1:0]  xpos,
    input  logic [game_pkg::POS_W-1:0]  ypos,
    input  logic                        ladder,
    input  game_pkg::slope_e            slope,
    input  logic                        on_edge,
    output logic                        wb_ack,
    output logic [15:0]                 wb_dat_r,
    output logic                        cmd_start,
    output game_pkg::cmd_e              cmd_op,
    output logic [7:0]                  cmd_steps,
    output logic                        load_x,
    output logic                        load_y,
    output logic [game_pkg::POS_W-1:0]  load_val
);

    import game_pkg::*;

    logic   bus_cycle;
    logic   stb_seen;
    logic   ack_now;
    logic   wr_ok;

    assign bus_cycle = wb_cyc && wb_stb;
    assign ack_now   = bus_cycle && !wb_ack && !stb_seen;
    assign wr_ok     = ack_now && wb_we && !busy;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_ack    <= 1'b0;
            stb_seen  <= 1'b0;
            cmd_start <= 1'b0;
            load_x    <= 1'b0;
            load_y    <= 1'b0;
        end else begin
            wb_ack    <= ack_now;
            stb_seen  <= bus_cycle;     // low again once the master drops the strobe.
            cmd_start <= wr_ok && (wb_adr == REG_CMD);
            load_x    <= wr_ok && (wb_adr == REG_X);
            load_y    <= wr_ok && (wb_adr == REG_Y);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            cmd_op    <= cmd_e'(wb_dat_w[2:0]);
            cmd_steps <= wb_dat_w[15:8];
            load_val  <= wb_dat_w[POS_W-1:0];
        end
        if (ack_now) begin
            case (wb_adr)
                REG_X:      wb_dat_r <= 16'(xpos);
                REG_Y:      wb_dat_r <= 16'(ypos);
                REG_STATUS: wb_dat_r <= {11'd0, on_edge, slope, ladder, busy};
                default:    wb_dat_r <= 16'd0;      // the command register reads as zero.
            endcase
        end
    end

endmodule

// File: src/pos_update.sv
//####################################################################
// ramp correction applies only when x really moved by one pixel.
// a fall never passes land_y, it snaps there if already below it.
//####################################################################

module pos_update (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        load_x,
    input  logic                        load_y,
    input  logic [game_pkg::POS_W-1:0]  load_val,
    input  logic                        step_en,
    input  game_pkg::cmd_e              step_op,
    input  logic                        fall_en,
    input  game_pkg::slope_e            slope,
    input  logic [game_pkg::POS_W-1:0]  limit_ymin,
    input  logic [game_pkg::POS_W-1:0]  limit_ymax,
    input  logic [game_pkg::POS_W-1:0]  land_y,
    output logic [game_pkg::POS_W-1:0]  xpos,
    output logic [game_pkg::POS_W-1:0]  ypos,
    output logic                        landed
);

    import game_pkg::*;

    logic [POS_W-1:0]   x_nxt;
    logic [POS_W-1:0]   y_nxt;
    logic               x_moved;

    always_ff @(posedge clk) begin
        if (rst) begin
            xpos <= '0;
            ypos <= '0;
        end else begin
            xpos <= x_nxt;
            ypos <= y_nxt;
        end
    end

    always_comb begin
        x_nxt   = xpos;
        y_nxt   = ypos;
        x_moved = 1'b0;
        if (load_x || load_y) begin
            if (load_x) x_nxt = load_val;
            if (load_y) y_nxt = load_val;
        end else if (fall_en) begin
            y_nxt = (ypos < land_y) ? ypos + 1'b1 : land_y;
        end else if (step_en) begin
            case (step_op)
                CMD_LEFT:  if (xpos != '0) begin
                    x_nxt   = xpos - 1'b1;
                    x_moved = 1'b1;
                end
                CMD_RIGHT: if (int'(xpos) < HOR_PIXELS - CHAR_WIDTH) begin
                    x_nxt   = xpos + 1'b1;
                    x_moved = 1'b1;
                end
                CMD_UP:    if (ypos > limit_ymin) y_nxt = ypos - 1'b1;
                CMD_DOWN:  if (ypos < limit_ymax) y_nxt = ypos + 1'b1;
                default:   x_moved = 1'b0;
            endcase
            // on a ramp y follows the slope once every RAMP_RUN pixels of x.
            if (x_moved && (slope != SLOPE_FLAT) && ((int'(x_nxt) % RAMP_RUN) == 0)) begin
                if ((slope == SLOPE_DOWN_RIGHT) == (step_op == CMD_RIGHT))
                    y_nxt = ypos + 1'b1;
                else
                    y_nxt = ypos - 1'b1;
            end
        end
    end

    assign landed = fall_en && (ypos == land_y);

endmodule

// File: src/move_ctrl.sv
//####################################################################
// one step costs three clocks, so map flags are fresh in ST_DECIDE.
// a climb step away from a ladder is skipped but still counted.
//####################################################################

module move_ctrl (
    input  logic            clk,
    input  logic            rst,
    input  logic            cmd_start,
    input  game_pkg::cmd_e  cmd_op,
    input  logic [7:0]      cmd_steps,
    input  logic            ladder,
    input  logic            on_edge,
    input  logic            landed,
    output logic            busy,
    output logic            step_en,
    output game_pkg::cmd_e  step_op,
    output logic            fall_en
);

    import game_pkg::*;

    move_state_e    state;
    move_state_e    state_nxt;
    logic [7:0]     steps_left;
    logic [7:0]     steps_left_nxt;
    cmd_e           op_nxt;
    logic           horizontal;
    logic           cmd_valid;

    assign horizontal = (step_op == CMD_LEFT) || (step_op == CMD_RIGHT);
    assign cmd_valid  = (cmd_op inside {CMD_LEFT, CMD_RIGHT, CMD_UP, CMD_DOWN}) &&
                        (cmd_steps != 8'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ST_IDLE;
            steps_left <= 8'd0;
            step_op    <= CMD_NOP;
        end else begin
            state      <= state_nxt;
            steps_left <= steps_left_nxt;
            step_op    <= op_nxt;
        end
    end

    always_comb begin
        state_nxt      = state;
        steps_left_nxt = steps_left;
        op_nxt         = step_op;
        case (state)
            ST_IDLE: begin
                if (cmd_start && cmd_valid) begin   // nop and zero counts never leave idle.
                    op_nxt         = cmd_op;
                    steps_left_nxt = cmd_steps;
                    state_nxt      = ST_STEP;
                end
            end
            ST_STEP: begin
                steps_left_nxt = steps_left - 8'd1;
                state_nxt      = ST_SETTLE;
            end
            ST_SETTLE: begin
                state_nxt = ST_DECIDE;
            end
            ST_DECIDE: begin
                if (horizontal && on_edge) begin
                    state_nxt = ST_FALL;            // the rest of the walk is dropped.
                end else if (steps_left == 8'd0) begin
                    state_nxt = ST_IDLE;
                end else begin
                    state_nxt = ST_STEP;
                end
            end
            ST_FALL: begin
                if (landed) begin
                    state_nxt = ST_IDLE;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    assign busy    = (state != ST_IDLE);
    assign step_en = (state == ST_STEP) && (horizontal || ladder);
    assign fall_en = (state == ST_FALL);

endmodule

// File: src/map_control.sv
//####################################################################
// outputs follow a position change one clock later.
// limits and landing height hold their last value when nothing matches.
//####################################################################

module map_control (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [game_pkg::POS_W-1:0]  xpos,
    input  logic [game_pkg::POS_W-1:0]  ypos,
    output logic                        ladder,
    output logic [game_pkg::POS_W-1:0]  limit_ymin,
    output logic [game_pkg::POS_W-1:0]  limit_ymax,
    output game_pkg::slope_e            slope,
    output logic                        on_edge,
    output logic [game_pkg::POS_W-1:0]  land_y
);

    import game_pkg::*;

    logic               ladder_nxt;
    logic [POS_W-1:0]   limit_ymin_nxt;
    logic [POS_W-1:0]   limit_ymax_nxt;
    slope_e             slope_nxt;
    logic               on_edge_nxt;
    logic [POS_W-1:0]   land_y_nxt;

    always_ff @(posedge clk) begin : out_reg_blk
        if (rst) begin
            ladder     <= 1'b0;
            limit_ymin <= '0;
            limit_ymax <= '0;
            slope      <= SLOPE_FLAT;
            on_edge    <= 1'b0;
            land_y     <= '0;
        end else begin
            ladder     <= ladder_nxt;
            limit_ymin <= limit_ymin_nxt;
            limit_ymax <= limit_ymax_nxt;
            slope      <= slope_nxt;
            on_edge    <= on_edge_nxt;
            land_y     <= land_y_nxt;
        end
    end

    // the tables are scanned from the top, so the lowest index is written last and wins.
    always_comb begin : ladder_blk
        ladder_nxt     = 1'b0;
        limit_ymin_nxt = limit_ymin;
        limit_ymax_nxt = limit_ymax;
        for (int k = LADDER_COUNT - 1; k >= 0; k--) begin
            if ((int'(ypos) >= LADDER_VSTART[k] - CHAR_HEIGHT) &&
                (int'(ypos) <= LADDER_VSTOP[k]) &&
                (int'(xpos) >= LADDER_HSTART[k] - LADDER_OFFSET) &&
                (int'(xpos) <= LADDER_HSTART[k] - LADDER_OFFSET + LADDER_WIDTH)) begin
                ladder_nxt     = 1'b1;
                limit_ymin_nxt = POS_W'(LADDER_VSTART[k] - CHAR_HEIGHT);
                limit_ymax_nxt = POS_W'(LADDER_VSTOP[k] - CHAR_HEIGHT);
            end
        end
    end

    always_comb begin : ramp_blk
        slope_nxt = SLOPE_FLAT;
        for (int k = RAMP_COUNT - 1; k >= 0; k--) begin
            if ((int'(xpos) >= RAMP_XMIN[k]) && (int'(xpos) <= RAMP_XMAX[k]) &&
                (int'(ypos) >= RAMP_YMIN[k]) && (int'(ypos) <= RAMP_YMAX[k])) begin
                slope_nxt = RAMP_DIR[k];
            end
        end
    end

    always_comb begin : edge_blk
        on_edge_nxt = 1'b0;
        land_y_nxt  = land_y;
        for (int k = EDGE_COUNT - 1; k >= 0; k--) begin
            if ((int'(xpos) >= EDGE_XMIN[k]) && (int'(xpos) <= EDGE_XMAX[k]) &&
                (int'(ypos) >= EDGE_YMIN[k]) && (int'(ypos) <= EDGE_YMAX[k])) begin
                on_edge_nxt = 1'b1;
                land_y_nxt  = POS_W'(EDGE_LAND[k]);
            end
        end
    end

endmodule

// File: src/game_pkg.sv
//####################################################################
// level geometry is fixed for a 64 x 64 character on a 1024 x 768 screen.
// every table value must stay at or above the character size offsets.
//####################################################################

package game_pkg;

    localparam int HOR_PIXELS  = 1024;
    localparam int VER_PIXELS  = 768;
    localparam int CHAR_WIDTH  = 64;
    localparam int CHAR_HEIGHT = 64;
    localparam int POS_W       = 11;

    typedef enum logic [1:0] {
        SLOPE_FLAT,
        SLOPE_DOWN_RIGHT,      // y grows as x grows.
        SLOPE_UP_RIGHT
    } slope_e;

    typedef enum logic [2:0] {
        CMD_NOP,
        CMD_LEFT,
        CMD_RIGHT,
        CMD_UP,
        CMD_DOWN
    } cmd_e;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_STEP,
        ST_SETTLE,
        ST_DECIDE,
        ST_FALL
    } move_state_e;

    localparam int LADDER_COUNT  = 4;
    localparam int LADDER_WIDTH  = 32;
    localparam int LADDER_OFFSET = 16;
    localparam int LADDER_HSTART [LADDER_COUNT] = '{300, 700, 150, 850};
    localparam int LADDER_VSTART [LADDER_COUNT] = '{500, 300, 300, 100};
    localparam int LADDER_VSTOP  [LADDER_COUNT] = '{700, 500, 500, 300};

    // ramp boxes are given in character top-left coordinates.
    localparam int RAMP_COUNT = 3;
    localparam int RAMP_RUN   = 8;
    localparam int RAMP_XMIN [RAMP_COUNT] = '{400, 100, 500};
    localparam int RAMP_XMAX [RAMP_COUNT] = '{560, 260, 660};
    localparam int RAMP_YMIN [RAMP_COUNT] = '{420, 620, 220};
    localparam int RAMP_YMAX [RAMP_COUNT] = '{452, 652, 252};
    localparam slope_e RAMP_DIR [RAMP_COUNT] = '{SLOPE_DOWN_RIGHT, SLOPE_UP_RIGHT,
                                                 SLOPE_DOWN_RIGHT};

    // landing heights are already reduced by the character height.
    localparam int EDGE_COUNT = 3;
    localparam int EDGE_XMIN [EDGE_COUNT] = '{900, 0, 900};
    localparam int EDGE_XMAX [EDGE_COUNT] = '{960, 40, 960};
    localparam int EDGE_YMIN [EDGE_COUNT] = '{430, 230, 30};
    localparam int EDGE_YMAX [EDGE_COUNT] = '{440, 240, 42};
    localparam int EDGE_LAND [EDGE_COUNT] = '{636, 436, 236};

    localparam logic [1:0] REG_CMD    = 2'd0;
    localparam logic [1:0] REG_X      = 2'd1;
    localparam logic [1:0] REG_Y      = 2'd2;
    localparam logic [1:0] REG_STATUS = 2'd3;

endpackage
